// File: Makefile
VERILATOR ?= verilator
TOP       ?= codebook_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: list.f
+incdir+tests
logic/huff_pkg.sv
logic/htree_ram.sv
logic/codebook_walker.sv
logic/code_sender.sv
logic/huff_codebook_top.sv
tests/codebook_tb.sv

// File: logic/code_sender.sv
`timescale 1ns/1ns
module code_sender #(
  parameter int FIFO_DEPTH = 4,
  parameter int CREDITS    = 2
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                push,
  input  huff_pkg::cb_entry_t entry,
  output logic                room,
  output logic                out_valid,
  output huff_pkg::cb_entry_t out_entry,
  input  logic                credit_return
);
  import huff_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam int CRD_W = $clog2(CREDITS + 1);

  cb_entry_t        queue [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;      // entries waiting in the queue
  logic [CRD_W-1:0] credit_cnt; // slots the receiver still has free

  // wraps at FIFO_DEPTH so any depth works, not only powers of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + PTR_W'(1);
  endfunction

  assign room      = (count != CNT_W'(FIFO_DEPTH));
  assign out_valid = (count != '0) && (credit_cnt != '0); // one entry leaves per cycle
  assign out_entry = queue[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      queue[wr_ptr] <= entry;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      credit_cnt <= CRD_W'(CREDITS); // receiver starts with all slots free
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (out_valid) begin
        rd_ptr <= next_ptr(rd_ptr);
      end

      case ({push, out_valid})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count; // both or neither leave the fill level alone
      endcase

      case ({out_valid, credit_return})
        2'b10:   credit_cnt <= credit_cnt - CRD_W'(1);
        2'b01:   credit_cnt <= credit_cnt + CRD_W'(1);
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  // the walker has to respect room, otherwise an entry is overwritten
  a_no_push_full: assert property (@(posedge clk) disable iff (rst)
    push |-> (count != CNT_W'(FIFO_DEPTH)));

  // more returns than sends means the receiver freed a slot twice
  a_credit_max: assert property (@(posedge clk) disable iff (rst)
    credit_cnt <= CRD_W'(CREDITS));

endmodule

// File: logic/codebook_walker.sv
`timescale 1ns/1ns
module codebook_walker (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  huff_pkg::node_idx_t   root,
  output logic                  busy,
  output logic                  finished,
  output huff_pkg::node_idx_t   rd_addr,
  input  huff_pkg::htree_node_t rd_node,
  output logic                  push,
  output huff_pkg::cb_entry_t   entry,
  input  logic                  room
);
  import huff_pkg::*;

  walk_state_t state;
  node_idx_t   root_q;  // root of the tree being walked
  code_t       path;    // moves from the root, bit k is move k
  code_len_t   depth;   // number of valid moves in path
  code_len_t   step;    // moves taken so far on the current walk

  logic       cur_dir;   // branch taken at the node now on rd_node
  child_ref_t cur_child;
  code_len_t  last;      // position of the newest move in path
  code_len_t  step_inc;
  logic       at_node;   // a tree node is being evaluated this cycle
  logic       can_start;

  always_comb begin
    // during a re-walk the stored path picks the side, otherwise go left
    cur_dir    = (state == RETRACK) ? path[step[4:0]] : 1'b0;
    cur_child  = cur_dir ? rd_node.right : rd_node.left;
    last       = depth - code_len_t'(1);
    step_inc   = step + code_len_t'(1);
    at_node    = (state == DESCEND) || (state == RETRACK);
    can_start  = start && ((state == IDLE) || (state == DONE));
  end

  assign push     = (state == EMIT) && room; // the queue only accepts when not full
  assign finished = (state == DONE);
  assign busy     = (state != IDLE) && (state != DONE);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state   <= IDLE;
      path    <= '0;
      depth   <= '0;
      step    <= '0;
      root_q  <= '0;
      rd_addr <= '0;
    end else begin
      case (state)
        IDLE, DONE: begin
          if (can_start) begin
            state   <= FETCH;
            path    <= '0;
            depth   <= '0;
            step    <= '0;
            root_q  <= root;
            rd_addr <= root; // first read goes out the cycle after start
          end
        end

        FETCH: begin
          // still inside the known path means this is a re-walk
          state <= (step < depth) ? RETRACK : DESCEND;
        end

        DESCEND, RETRACK: begin
          step <= step_inc;
          if (state == DESCEND) begin
            depth <= step_inc; // the new left move is a 0 that is already in path
          end
          if (cur_child.is_empty) begin
            state <= BACKTRACK; // nothing to emit on this side
          end else if (cur_child.is_sum) begin
            rd_addr <= cur_child.ref_val[6:0];
            state   <= FETCH;
          end else begin
            state <= EMIT;
          end
        end

        EMIT: begin
          if (room) begin
            state <= BACKTRACK;
          end
        end

        BACKTRACK: begin
          // one move is examined per cycle, newest first
          if (depth == '0) begin
            state <= DONE; // every left move has been turned right
          end else if (path[last[4:0]]) begin
            path[last[4:0]] <= 1'b0; // drop a right move that is fully explored
            depth           <= last;
          end else begin
            path[last[4:0]] <= 1'b1; // try the right side of that node next
            step            <= '0;
            rd_addr         <= root_q;
            state           <= FETCH;
          end
        end

        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // leaf entry is captured once and held while EMIT waits for room
  always_ff @(posedge clk) begin
    if (at_node && !cur_child.is_empty && !cur_child.is_sum) begin
      entry <= '{sym: cur_child.ref_val, code: path, len: step_inc};
    end
  end

  // a stalled entry must not move or change until the queue takes it
  a_emit_stall: assert property (@(posedge clk) disable iff (rst)
    (state == EMIT && !room) |=> (state == EMIT && $stable(entry)));

  // a tree deeper than the code word would corrupt the path register
  a_depth_max: assert property (@(posedge clk) disable iff (rst)
    depth <= MAX_DEPTH);

  // a finished walk stays finished until a new start makes it busy again
  a_finish_excl: assert property (@(posedge clk) disable iff (rst)
    finished |-> !busy ##1 (finished || busy));

endmodule

// File: logic/htree_ram.sv
`timescale 1ns/1ns
module htree_ram (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  load_en,
  input  huff_pkg::node_idx_t   load_addr,
  input  huff_pkg::htree_node_t load_node,
  input  huff_pkg::node_idx_t   rd_addr,
  output huff_pkg::htree_node_t rd_node
);
  import huff_pkg::*;

  localparam int NODES = 2 ** $bits(node_idx_t); // one slot per possible node index

  htree_node_t mem [NODES];

  // tree image is written one node per cycle before the walk starts
  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_node;
    end
  end

  // registered read, so the node shows up one cycle after its address
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rd_node <= '0;
    end else begin
      rd_node <= mem[rd_addr]; // a same-cycle write returns the old node
    end
  end

endmodule

// File: logic/huff_codebook_top.sv
`timescale 1ns/1ns
module huff_codebook_top #(
  parameter int FIFO_DEPTH = 4,
  parameter int CREDITS    = 2
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  load_en,
  input  huff_pkg::node_idx_t   load_addr,
  input  huff_pkg::htree_node_t load_node,
  input  logic                  start,
  input  huff_pkg::node_idx_t   root,
  output logic                  busy,
  output logic                  finished,
  output logic                  out_valid,
  output huff_pkg::cb_entry_t   out_entry,
  input  logic                  credit_return
);
  import huff_pkg::*;

  node_idx_t   rd_addr;
  htree_node_t rd_node;
  logic        walk_push;
  cb_entry_t   walk_entry;
  logic        room;

  htree_ram u_ram (
    .clk       (clk),
    .rst       (rst),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_node (load_node),
    .rd_addr   (rd_addr),
    .rd_node   (rd_node)
  );

  codebook_walker u_walker (
    .clk      (clk),
    .rst      (rst),
    .start    (start),
    .root     (root),
    .busy     (busy),
    .finished (finished),
    .rd_addr  (rd_addr),
    .rd_node  (rd_node),
    .push     (walk_push),
    .entry    (walk_entry),
    .room     (room)
  );

  code_sender #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .CREDITS    (CREDITS)
  ) u_sender (
    .clk           (clk),
    .rst           (rst),
    .push          (walk_push),
    .entry         (walk_entry),
    .room          (room),
    .out_valid     (out_valid),
    .out_entry     (out_entry),
    .credit_return (credit_return)
  );

  // tree memory must not change under a running walk
  a_load_idle: assert property (@(posedge clk) disable iff (rst)
    load_en |-> !busy);

  // finished only comes out of an exhausted backtrack, after the last push
  a_finish_src: assert property (@(posedge clk) disable iff (rst)
    $rose(finished) |-> ($past(u_walker.state) == BACKTRACK) && !walk_push);

endmodule

// File: logic/huff_pkg.sv
package huff_pkg;

  localparam int MAX_DEPTH = 32; // longest code the walker can produce

  typedef logic [6:0] node_idx_t; // tree memory address
  typedef logic [7:0] symbol_t;

  // one side of an internal node
  typedef struct packed {
    logic is_sum;    // child is another internal node
    logic is_empty;  // no child on this side
    logic [7:0] ref_val; // symbol value or node index, depending on is_sum
  } child_ref_t;

  typedef struct packed {
    child_ref_t left;
    child_ref_t right;
  } htree_node_t;

  typedef logic [31:0] code_t;    // bit k holds the k-th move, 1 means right
  typedef logic [5:0]  code_len_t; // 1 to 32 for a valid entry

  // one codebook line as it leaves the block
  typedef struct packed {
    symbol_t   sym;
    code_t     code;
    code_len_t len;
  } cb_entry_t;

  typedef enum logic [2:0] {
    IDLE,      // nothing started since reset
    FETCH,     // waiting for the tree memory read
    DESCEND,   // fresh descent, always takes the left branch
    EMIT,      // holding a leaf entry until the queue has room
    BACKTRACK, // trims the path to the next untried right branch
    RETRACK,   // re-walk from the root following the stored path
    DONE       // every leaf has been pushed
  } walk_state_t;

endpackage

// File: tests/codebook_model.svh
`ifndef CODEBOOK_MODEL_SVH
`define CODEBOOK_MODEL_SVH

  htree_node_t tree_mem [128]; // image of the tree as it goes into the DUT
  node_idx_t   tree_nodes [$]; // indexes written by the last builder
  cb_entry_t   exp_q [$];      // expected codebook, oldest entry first

  function automatic child_ref_t leaf_ref(input symbol_t sym);
    return '{is_sum: 1'b0, is_empty: 1'b0, ref_val: sym};
  endfunction

  function automatic child_ref_t sum_ref(input node_idx_t idx);
    return '{is_sum: 1'b1, is_empty: 1'b0, ref_val: {1'b0, idx}};
  endfunction

  function automatic child_ref_t empty_ref();
    return '{is_sum: 1'b0, is_empty: 1'b1, ref_val: 8'h00};
  endfunction

  task automatic put_node(input node_idx_t idx, input child_ref_t l, input child_ref_t r);
    tree_mem[idx] = '{left: l, right: r};
    tree_nodes.push_back(idx);
  endtask

  task automatic build_balanced(input node_idx_t base);
    put_node(base, sum_ref(base + 7'd1), sum_ref(base + 7'd2));
    put_node(base + 7'd1, leaf_ref(8'h11), leaf_ref(8'h22));
    put_node(base + 7'd2, leaf_ref(8'h33), leaf_ref(8'h44));
  endtask

  task automatic build_skewed(input node_idx_t base);
    node_idx_t idx;
    int        i;
    for (i = 0; i < 7; i++) begin
      idx = node_idx_t'(int'(base) + i);
      put_node(idx, leaf_ref(symbol_t'(8'h40 + i)), sum_ref(idx + 7'd1));
    end
    put_node(base + 7'd7, leaf_ref(8'h47), leaf_ref(8'h48)); // deepest pair sits 8 moves down
  endtask

  task automatic build_single(input node_idx_t base);
    put_node(base, leaf_ref(8'h5a), empty_ref());
  endtask

  task automatic build_full(input node_idx_t base);
    node_idx_t idx;
    int        i;
    for (i = 0; i < 15; i++) begin
      idx = node_idx_t'(int'(base) + i);
      if (i < 7) begin
        put_node(idx, sum_ref(node_idx_t'(int'(base) + 2 * i + 1)),
                 sum_ref(node_idx_t'(int'(base) + 2 * i + 2))); // heap layout
      end else begin
        put_node(idx, leaf_ref(symbol_t'(8'h80 + 2 * i)), leaf_ref(symbol_t'(8'h81 + 2 * i)));
      end
    end
  endtask

  // bias out of 16 sets how often a child becomes another internal node
  task automatic build_random(input node_idx_t base, input int max_nodes, input int bias);
    node_idx_t   work_idx [$];
    int          work_depth [$];
    node_idx_t   cur;
    int          depth;
    int          used;
    int          s;
    logic [31:0] r;
    child_ref_t  side [2];
    used = 1;
    work_idx.push_back(base);
    work_depth.push_back(0);
    while (work_idx.size() > 0) begin
      cur   = work_idx.pop_back();
      depth = work_depth.pop_back();
      for (s = 0; s < 2; s++) begin
        r = next_rand();
        if (r[2:0] == 3'd0) begin
          side[s] = empty_ref();
        end else if (used < max_nodes && depth < MAX_DEPTH - 1 && int'(r[7:4]) < bias) begin
          side[s] = sum_ref(node_idx_t'(int'(base) + used));
          work_idx.push_back(node_idx_t'(int'(base) + used));
          work_depth.push_back(depth + 1); // children of this node get codes of depth + 2
          used++;
        end else begin
          side[s] = leaf_ref(r[15:8]);
        end
      end
      put_node(cur, side[0], side[1]);
    end
  endtask

  // left-first depth-first walk, a right child is stacked under its left sibling
  task automatic model_codebook(input node_idx_t root_idx);
    child_ref_t st_ref [$];
    code_t      st_code [$];
    int         st_len [$];
    child_ref_t c;
    code_t      cur_code;
    int         cur_len;
    cb_entry_t  e;
    exp_q.delete();
    st_ref.push_back(tree_mem[root_idx].right);
    st_code.push_back(code_t'(1));
    st_len.push_back(1);
    st_ref.push_back(tree_mem[root_idx].left);
    st_code.push_back('0);
    st_len.push_back(1);
    while (st_ref.size() > 0) begin
      c        = st_ref.pop_back();
      cur_code = st_code.pop_back();
      cur_len  = st_len.pop_back();
      // an absent child adds nothing to the codebook
      if (!c.is_empty && c.is_sum) begin
        st_ref.push_back(tree_mem[c.ref_val[6:0]].right);
        st_code.push_back(cur_code | (code_t'(1) << cur_len));
        st_len.push_back(cur_len + 1);
        st_ref.push_back(tree_mem[c.ref_val[6:0]].left);
        st_code.push_back(cur_code);
        st_len.push_back(cur_len + 1);
      end else if (!c.is_empty) begin
        e.sym  = c.ref_val;
        e.code = cur_code;
        e.len  = code_len_t'(cur_len);
        exp_q.push_back(e);
      end
    end
  endtask

`endif

// File: tests/codebook_tb.sv
`timescale 1ns/1ns
module codebook_tb;
  import huff_pkg::*;

  localparam int FIFO_DEPTH = 4;
  localparam int CREDITS    = 2;
  localparam int TIMEOUT    = 30000; // cycles allowed for one codebook

  typedef enum logic [2:0] {
    KIND_BALANCED, KIND_SKEWED, KIND_SINGLE, KIND_FULL, KIND_RANDOM, KIND_DEEP
  } tree_kind_t;

  typedef struct packed {
    tree_kind_t kind;
    node_idx_t  base;  // root index, the tree is placed from here upwards
    logic [7:0] delay; // cycles from receiving an entry to returning its credit
  } case_t;

  localparam int NUM_CASES = 11;
  localparam case_t CASES [NUM_CASES] = '{
    '{KIND_BALANCED, 7'd0,   8'd0},
    '{KIND_SKEWED,   7'd10,  8'd1},
    '{KIND_SINGLE,   7'd20,  8'd0},
    '{KIND_FULL,     7'd30,  8'd2},
    '{KIND_FULL,     7'd50,  8'd25}, // long hold, the queue fills and the walker stalls
    '{KIND_SKEWED,   7'd70,  8'd12},
    '{KIND_RANDOM,   7'd0,   8'd0},
    '{KIND_RANDOM,   7'd64,  8'd3},
    '{KIND_DEEP,     7'd0,   8'd1},
    '{KIND_DEEP,     7'd60,  8'd9},
    '{KIND_SINGLE,   7'd100, 8'd30}
  };

  logic        clk;
  logic        rst;
  logic        load_en;
  node_idx_t   load_addr;
  htree_node_t load_node;
  logic        start;
  node_idx_t   root;
  logic        busy;
  logic        finished;
  logic        out_valid;
  cb_entry_t   out_entry;
  logic        credit_return;

  int          errors;
  int          timeouts;
  int          total_entries;
  logic [31:0] rng_state;

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  `include "codebook_model.svh"

  huff_codebook_top #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .CREDITS    (CREDITS)
  ) dut (
    .clk           (clk),
    .rst           (rst),
    .load_en       (load_en),
    .load_addr     (load_addr),
    .load_node     (load_node),
    .start         (start),
    .root          (root),
    .busy          (busy),
    .finished      (finished),
    .out_valid     (out_valid),
    .out_entry     (out_entry),
    .credit_return (credit_return)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_entry(input cb_entry_t got, input cb_entry_t exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: entry %h/%h/%0d, expected %h/%h/%0d",
               $time, got.sym, got.code, got.len, exp.sym, exp.code, exp.len);
    end
  endtask

  task automatic check_count(input int got, input int exp);
    if (got != exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %0d entries, expected %0d", $time, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic build_tree(input tree_kind_t kind, input node_idx_t base);
    tree_nodes.delete();
    case (kind)
      KIND_BALANCED: build_balanced(base);
      KIND_SKEWED:   build_skewed(base);
      KIND_SINGLE:   build_single(base);
      KIND_FULL:     build_full(base);
      KIND_RANDOM:   build_random(base, 20, 8);
      default:       build_random(base, 60, 13); // long chains, codes up to 32 bits
    endcase
  endtask

  task automatic load_tree();
    foreach (tree_nodes[i]) begin
      @(negedge clk);
      load_en   = 1'b1;
      load_addr = tree_nodes[i];
      load_node = tree_mem[tree_nodes[i]];
    end
    @(negedge clk);
    load_en = 1'b0;
  endtask

  task automatic run_case(input int idx, input case_t tc);
    int cycle;
    int received;
    int returned;
    int expected;
    int k;
    int pending [$]; // cycles at which the receiver frees a slot
    bit saw_finish;
    bit complete;
    cycle      = 0;
    received   = 0;
    returned   = 0;
    saw_finish = 1'b0;
    complete   = 1'b0;
    build_tree(tc.kind, tc.base);
    load_tree();
    model_codebook(tc.base);
    expected = exp_q.size();
    @(negedge clk);
    start = 1'b1;
    root  = tc.base;
    @(negedge clk);
    start = 1'b0;
    check_bit("busy after start", busy, 1'b1);
    while (!complete && cycle < TIMEOUT) begin
      if (out_valid) begin
        received++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("case %0d: an entry arrived beyond the expected codebook", idx);
        end else begin
          check_entry(out_entry, exp_q.pop_front());
        end
        check_bit("credit limit held", (received - returned) <= CREDITS, 1'b1);
        pending.push_back(cycle + int'(tc.delay));
      end
      if (pending.size() > 0 && pending[0] <= cycle) begin
        credit_return = 1'b1;
        returned++;
        void'(pending.pop_front());
      end else begin
        credit_return = 1'b0;
      end
      if (finished) begin
        if (!saw_finish) begin
          // every entry is pushed by now, so only queued ones may be missing
          check_bit("entries left at finish fit the queue",
                    exp_q.size() <= FIFO_DEPTH, 1'b1);
        end
        saw_finish = 1'b1;
        check_bit("busy while finished", busy, 1'b0);
      end else if (saw_finish) begin
        check_bit("finished held until the next start", finished, 1'b1);
      end
      complete = saw_finish && (exp_q.size() == 0) && (pending.size() == 0);
      @(negedge clk);
      cycle++;
    end
    if (!complete) begin
      timeouts++;
      $display("case %0d: codebook did not complete within %0d cycles", idx, TIMEOUT);
    end
    credit_return = 1'b0;
    for (k = 0; k < 6; k++) begin
      check_bit("out_valid after codebook", out_valid, 1'b0); // nothing left to send
      @(negedge clk);
    end
    check_count(received, expected);
    total_entries += received;
  endtask

  initial begin
    int i;
    rst           = 1'b1;
    load_en       = 1'b0;
    load_addr     = '0;
    load_node     = '0;
    start         = 1'b0;
    root          = '0;
    credit_return = 1'b0;
    errors        = 0;
    timeouts      = 0;
    total_entries = 0;
    rng_state     = 32'h5218;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    for (i = 0; i < 4; i++) begin
      @(negedge clk);
      check_bit("out_valid after reset", out_valid, 1'b0);
      check_bit("busy after reset", busy, 1'b0);
      check_bit("finished after reset", finished, 1'b0);
    end
    for (i = 0; i < NUM_CASES && timeouts == 0; i++) begin
      run_case(i, CASES[i]);
    end
    $display("errors: %0d failed checks, %0d timeouts, %0d entries received",
             errors, timeouts, total_entries);
    if (errors == 0 && timeouts == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
